// ==== files.f ====
source/cache_pkg.sv
source/tag_cam.sv
source/cache_data_mem.sv
source/plru_tree.sv
source/word_fifo.sv
source/cache_fa_controller.sv
source/cache_fa_top.sv
verif/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module cache_tb -o cache_tb_sim

./obj_dir/cache_tb_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== verif/cache_tb.sv ====
module cache_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import cache_pkg::*;

	localparam int N_REQ          = 16;
	localparam int TIMEOUT_CYCLES = N_REQ * 40;

	// one table row per core request
	typedef struct packed {
		mem_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
		logic              hit;      // expected hit
		logic [1:0]        n_cmd;    // expected memory commands
		logic [TAG_W-1:0]  wb_block; // expected write-back block, 2 commands only
	} stim_t;

	logic              clock;
	logic              resetn;
	logic              req_valid;
	core_req_t         req;
	logic              resp_valid;
	core_resp_t        resp;
	logic              cmd_valid;
	mem_cmd_t          cmd;
	logic              wdata_valid;
	logic [WORD_W-1:0] wdata;
	logic              rdata_valid;
	logic [WORD_W-1:0] rdata;
	logic              flag_hit;
	logic              flag_miss;
	logic              flag_wb;

	stim_t             stim [N_REQ];
	logic [WORD_W-1:0] mem_model [1 << ADDR_W]; // backing memory
	logic [WORD_W-1:0] ref_mem [1 << ADDR_W];   // expected contents seen by the core
	mem_op_e           cmd_op_log [64];
	logic [TAG_W-1:0]  cmd_block_log [64];

	int cmd_cnt;
	int err_cnt;
	int resp_cnt;
	int hit_cnt;
	int miss_cnt;
	int wb_cnt;
	int cycle_cnt = 0;

	// memory model state
	logic [31:0]        lfsr_state;
	logic [TAG_W-1:0]   rd_block;
	logic [BLOCK_W-1:0] rd_word;
	int                 rd_left;
	logic [1:0]         gap_left;
	logic [TAG_W-1:0]   wr_block;
	logic [BLOCK_W-1:0] wr_word;
	int                 wr_left;

	cache_fa_top u_dut (
		.clock_i           (clock),
		.resetn_i          (resetn),
		.core_req_valid_i  (req_valid),
		.core_req_i        (req),
		.core_resp_valid_o (resp_valid),
		.core_resp_o       (resp),
		.mem_cmd_valid_o   (cmd_valid),
		.mem_cmd_o         (cmd),
		.mem_wdata_valid_o (wdata_valid),
		.mem_wdata_o       (wdata),
		.mem_rdata_valid_i (rdata_valid),
		.mem_rdata_i       (rdata),
		.flag_hit_o        (flag_hit),
		.flag_miss_o       (flag_miss),
		.flag_writeback_o  (flag_wb)
	);

	always #5 clock = ~clock;

	// global run limit
	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: the DUT did not finish the requests in %0d cycles", cycle_cnt);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// -------------------------------------------------------------------------
	// helpers
	// -------------------------------------------------------------------------
	function automatic logic [WORD_W-1:0] pattern(input logic [ADDR_W-1:0] a);
		return {16'h0, a} ^ 32'h5a5a_0000;
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [1:0] draw_gap();
		logic [1:0] g;
		g = '0;
		for (int i = 0; i < 2; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			g          = {g[0], lfsr_state[0]};
		end
		return g;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	// one cycle, memory model and event counters on the falling edge
	task automatic step_cycle();
		@(negedge clock);
		if (resp_valid) resp_cnt++;
		if (flag_hit) hit_cnt++;
		if (flag_miss) miss_cnt++;
		if (flag_wb) wb_cnt++;

		// write-back words come back to back after MEM_WR
		if (wr_left != 0) begin
			compare("mem_wdata_valid_o", 32'(wdata_valid), 32'h1);
			if (wdata_valid) begin
				compare("mem_wdata_o", wdata, ref_mem[{wr_block, wr_word}]);
				mem_model[{wr_block, wr_word}] = wdata;
				wr_word++;
			end
			wr_left--;
		end else if (wdata_valid) begin
			compare("mem_wdata_valid_o", 32'h1, 32'h0); // stray word
		end

		// fill words with random gaps
		rdata_valid = 1'b0;
		if (rd_left != 0) begin
			if (gap_left == 2'd0) begin
				rdata_valid = 1'b1;
				rdata       = mem_model[{rd_block, rd_word}];
				rd_word++;
				rd_left--;
				gap_left    = draw_gap();
			end else begin
				gap_left--;
			end
		end

		if (cmd_valid) begin
			cmd_op_log[cmd_cnt]    = cmd.op;
			cmd_block_log[cmd_cnt] = cmd.block;
			cmd_cnt++;
			if (cmd.op == MEM_WR) begin
				wr_block = cmd.block;
				wr_word  = '0;
				wr_left  = BLOCK_WORDS;
			end else begin
				compare("write-back words left at MEM_RD", 32'(wr_left), 32'h0);
				rd_block = cmd.block;
				rd_word  = '0;
				rd_left  = BLOCK_WORDS;
				gap_left = draw_gap();
			end
		end
	endtask

	task automatic apply_request(input stim_t s);
		int          lat;
		int          base;
		int          n;
		logic [31:0] exp_data;
		step_cycle();
		base      = cmd_cnt;
		req_valid = 1'b1;
		req.op    = s.op;
		req.addr  = s.addr;
		req.wdata = s.wdata;
		if (s.op == MEM_WR) begin
			exp_data        = s.wdata; // stores echo their data
			ref_mem[s.addr] = s.wdata;
		end else begin
			exp_data = ref_mem[s.addr];
		end
		step_cycle();
		req_valid = 1'b0;
		req       = '0;
		lat       = 1;
		while (!resp_valid) begin
			step_cycle();
			lat++;
		end
		compare("core_resp_o.hit", 32'(resp.hit), 32'(s.hit));
		compare("core_resp_o.rdata", resp.rdata, exp_data);
		if (s.hit)
			compare("hit latency", 32'(lat), 32'd2);
		n = cmd_cnt - base;
		compare("mem_cmd count", 32'(n), 32'(s.n_cmd));
		if (n >= 1) begin // fill command is always last
			compare("mem_cmd_o.op", 32'(cmd_op_log[cmd_cnt-1]), 32'(MEM_RD));
			compare("mem_cmd_o.block", 32'(cmd_block_log[cmd_cnt-1]), 32'(s.addr[ADDR_W-1:BLOCK_W]));
		end
		if (n == 2) begin
			compare("mem_cmd_o.op", 32'(cmd_op_log[base]), 32'(MEM_WR));
			compare("mem_cmd_o.block", 32'(cmd_block_log[base]), 32'(s.wb_block));
		end
	endtask

	// -------------------------------------------------------------------------
	// stimulus table
	// A=0x010 B=0x020 C=0x030 D=0x040 E=0x050 (block addresses)
	// -------------------------------------------------------------------------
	task automatic load_table();
		stim[0]  = '{MEM_RD, 16'h0040, 32'h0,         1'b0, 2'd1, 14'h000}; // cold miss A
		stim[1]  = '{MEM_RD, 16'h0041, 32'h0,         1'b1, 2'd0, 14'h000};
		stim[2]  = '{MEM_WR, 16'h0042, 32'hc0de_0042, 1'b1, 2'd0, 14'h000}; // A dirty
		stim[3]  = '{MEM_RD, 16'h0042, 32'h0,         1'b1, 2'd0, 14'h000};
		stim[4]  = '{MEM_WR, 16'h0081, 32'hbeef_0081, 1'b0, 2'd1, 14'h000}; // allocate B
		stim[5]  = '{MEM_RD, 16'h0081, 32'h0,         1'b1, 2'd0, 14'h000};
		stim[6]  = '{MEM_RD, 16'h00c0, 32'h0,         1'b0, 2'd1, 14'h000}; // C
		stim[7]  = '{MEM_RD, 16'h0103, 32'h0,         1'b0, 2'd1, 14'h000}; // D, cache full
		stim[8]  = '{MEM_RD, 16'h0043, 32'h0,         1'b1, 2'd0, 14'h000}; // touch A
		stim[9]  = '{MEM_RD, 16'h0140, 32'h0,         1'b0, 2'd2, 14'h020}; // E evicts B
		stim[10] = '{MEM_RD, 16'h0042, 32'h0,         1'b1, 2'd0, 14'h000};
		stim[11] = '{MEM_RD, 16'h00c1, 32'h0,         1'b1, 2'd0, 14'h000};
		stim[12] = '{MEM_RD, 16'h0100, 32'h0,         1'b1, 2'd0, 14'h000};
		stim[13] = '{MEM_RD, 16'h0081, 32'h0,         1'b0, 2'd2, 14'h010}; // B back, A out
		stim[14] = '{MEM_WR, 16'h00c2, 32'h1234_00c2, 1'b1, 2'd0, 14'h000};
		stim[15] = '{MEM_RD, 16'h0042, 32'h0,         1'b0, 2'd1, 14'h000}; // A from memory
	endtask

	initial begin
		int exp_hits;
		int exp_wbs;
		clock       = 1'b0;
		resetn      = 1'b0;
		req_valid   = 1'b0;
		req         = '0;
		rdata_valid = 1'b0;
		rdata       = '0;
		lfsr_state  = 32'hd06e_af92;
		cmd_cnt     = 0;
		err_cnt     = 0;
		resp_cnt    = 0;
		hit_cnt     = 0;
		miss_cnt    = 0;
		wb_cnt      = 0;
		rd_left     = 0;
		wr_left     = 0;
		rd_block    = '0;
		rd_word     = '0;
		wr_block    = '0;
		wr_word     = '0;
		gap_left    = '0;
		for (int a = 0; a < (1 << ADDR_W); a++) begin
			mem_model[a] = pattern(16'(a));
			ref_mem[a]   = pattern(16'(a));
		end
		load_table();
		exp_hits = 0;
		exp_wbs  = 0;
		foreach (stim[i]) begin
			if (stim[i].hit) exp_hits++;
			if (stim[i].n_cmd == 2'd2) exp_wbs++;
		end

		repeat (4) @(negedge clock); // reset for 4 rising edges
		resetn = 1'b1;

		for (int i = 0; i < N_REQ; i++)
			apply_request(stim[i]);
		repeat (4) step_cycle(); // catch late strobes

		compare("response count", 32'(resp_cnt), 32'(N_REQ));
		compare("flag_hit_o count", 32'(hit_cnt), 32'(exp_hits));
		compare("flag_miss_o count", 32'(miss_cnt), 32'(N_REQ - exp_hits));
		compare("flag_writeback_o count", 32'(wb_cnt), 32'(exp_wbs));
		$display("summary: %0d requests, %0d memory commands, %0d errors",
			N_REQ, cmd_cnt, err_cnt);
		if (err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== source/cache_fa_top.sv ====
module cache_fa_top (
	input  logic                         clock_i,
	input  logic                         resetn_i,
	input  logic                         core_req_valid_i,
	input  cache_pkg::core_req_t         core_req_i,
	output logic                         core_resp_valid_o,
	output cache_pkg::core_resp_t        core_resp_o,
	output logic                         mem_cmd_valid_o,
	output cache_pkg::mem_cmd_t          mem_cmd_o,
	output logic                         mem_wdata_valid_o,
	output logic [cache_pkg::WORD_W-1:0] mem_wdata_o,
	input  logic                         mem_rdata_valid_i,
	input  logic [cache_pkg::WORD_W-1:0] mem_rdata_i,
	output logic                         flag_hit_o,
	output logic                         flag_miss_o,
	output logic                         flag_writeback_o
);
	import cache_pkg::*;

	// ------------------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------------------
	logic [TAG_W-1:0]          cam_tag;
	logic                      cam_hit;
	logic [LINE_W-1:0]         cam_line;
	logic                      cam_wr;
	logic [LINE_W-1:0]         cam_wr_line;  // also drives the tag read
	logic [TAG_W-1:0]          cam_rd_tag;
	logic [LINE_W+BLOCK_W-1:0] dmem_addr;
	logic                      dmem_we;
	logic [WORD_W-1:0]         dmem_wdata;
	logic [WORD_W-1:0]         dmem_rdata;
	logic                      plru_touch;
	logic [LINE_W-1:0]         plru_line;
	logic [LINE_W-1:0]         plru_victim;
	logic                      wb_push;
	logic [WORD_W-1:0]         wb_data;
	logic                      fill_empty;
	logic                      fill_pop;
	logic [WORD_W-1:0]         fill_data;

	cache_fa_controller u_ctrl (
		.clock_i           (clock_i),
		.resetn_i          (resetn_i),
		.core_req_valid_i  (core_req_valid_i),
		.core_req_i        (core_req_i),
		.core_resp_valid_o (core_resp_valid_o),
		.core_resp_o       (core_resp_o),
		.cam_tag_o         (cam_tag),
		.cam_hit_i         (cam_hit),
		.cam_line_i        (cam_line),
		.cam_wr_o          (cam_wr),
		.cam_wr_line_o     (cam_wr_line),
		.cam_rd_tag_i      (cam_rd_tag),
		.dmem_addr_o       (dmem_addr),
		.dmem_we_o         (dmem_we),
		.dmem_wdata_o      (dmem_wdata),
		.dmem_rdata_i      (dmem_rdata),
		.plru_touch_o      (plru_touch),
		.plru_line_o       (plru_line),
		.plru_victim_i     (plru_victim),
		.wb_push_o         (wb_push),
		.wb_data_o         (wb_data),
		.wb_pop_o          (mem_wdata_valid_o), // each pop sends one word
		.fill_empty_i      (fill_empty),
		.fill_pop_o        (fill_pop),
		.fill_data_i       (fill_data),
		.mem_cmd_valid_o   (mem_cmd_valid_o),
		.mem_cmd_o         (mem_cmd_o),
		.flag_hit_o        (flag_hit_o),
		.flag_miss_o       (flag_miss_o),
		.flag_writeback_o  (flag_writeback_o)
	);

	tag_cam u_cam (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.tag_i     (cam_tag),
		.hit_o     (cam_hit),
		.line_o    (cam_line),
		.wr_i      (cam_wr),
		.wr_line_i (cam_wr_line),
		.rd_line_i (cam_wr_line),
		.rd_tag_o  (cam_rd_tag)
	);

	cache_data_mem u_dmem (
		.clock_i (clock_i),
		.addr_i  (dmem_addr),
		.we_i    (dmem_we),
		.wdata_i (dmem_wdata),
		.rdata_o (dmem_rdata)
	);

	plru_tree u_plru (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.touch_i  (plru_touch),
		.line_i   (plru_line),
		.victim_o (plru_victim)
	);

	// memory to cache
	word_fifo u_fill_fifo (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.push_i   (mem_rdata_valid_i),
		.data_i   (mem_rdata_i),
		.pop_i    (fill_pop),
		.data_o   (fill_data),
		.empty_o  (fill_empty)
	);

	// cache to memory, head is the outgoing word
	word_fifo u_wb_fifo (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.push_i   (wb_push),
		.data_i   (wb_data),
		.pop_i    (mem_wdata_valid_o),
		.data_o   (mem_wdata_o),
		.empty_o  ()
	);

endmodule

// ==== source/cache_fa_controller.sv ====
module cache_fa_controller (
	input  logic                                           clock_i,
	input  logic                                           resetn_i,
	// core side
	input  logic                                           core_req_valid_i,
	input  cache_pkg::core_req_t                           core_req_i,
	output logic                                           core_resp_valid_o,
	output cache_pkg::core_resp_t                          core_resp_o,
	// tag cam
	output logic [cache_pkg::TAG_W-1:0]                    cam_tag_o,
	input  logic                                           cam_hit_i,
	input  logic [cache_pkg::LINE_W-1:0]                   cam_line_i,
	output logic                                           cam_wr_o,
	output logic [cache_pkg::LINE_W-1:0]                   cam_wr_line_o, // also tag read line
	input  logic [cache_pkg::TAG_W-1:0]                    cam_rd_tag_i,
	// data array
	output logic [cache_pkg::LINE_W+cache_pkg::BLOCK_W-1:0] dmem_addr_o,
	output logic                                           dmem_we_o,
	output logic [cache_pkg::WORD_W-1:0]                   dmem_wdata_o,
	input  logic [cache_pkg::WORD_W-1:0]                   dmem_rdata_i,
	// replacement
	output logic                                           plru_touch_o,
	output logic [cache_pkg::LINE_W-1:0]                   plru_line_o,
	input  logic [cache_pkg::LINE_W-1:0]                   plru_victim_i,
	// writeback fifo
	output logic                                           wb_push_o,
	output logic [cache_pkg::WORD_W-1:0]                   wb_data_o,
	output logic                                           wb_pop_o,
	// fill fifo
	input  logic                                           fill_empty_i,
	output logic                                           fill_pop_o,
	input  logic [cache_pkg::WORD_W-1:0]                   fill_data_i,
	// memory command
	output logic                                           mem_cmd_valid_o,
	output cache_pkg::mem_cmd_t                            mem_cmd_o,
	// event strobes
	output logic                                           flag_hit_o,
	output logic                                           flag_miss_o,
	output logic                                           flag_writeback_o
);
	import cache_pkg::*;

	ctrl_state_e       state_q;
	core_req_t         req_q;        // request held until the response
	logic              hit_q;
	logic [LINE_W-1:0] line_q;       // hit line, or victim line on a miss
	logic [BLOCK_W:0]  cnt_q;        // word counter, top bit marks 4 sent
	logic [LINES-1:0]  dirty_q;
	logic              rd_vld_q;     // array read issued last cycle
	logic              resp_valid_q;
	logic              flag_hit_q;
	logic              flag_miss_q;
	logic              flag_wb_q;

	logic [TAG_W-1:0]   req_tag;
	logic [BLOCK_W-1:0] req_word;
	logic               is_store;
	logic               last_word;

	assign req_tag   = req_q.addr[ADDR_W-1:BLOCK_W];
	assign req_word  = req_q.addr[BLOCK_W-1:0];
	assign is_store  = (req_q.op == MEM_WR);
	assign last_word = &cnt_q[BLOCK_W-1:0];

	// ------------------------------------------------------------------------
	// state machine and control state
	// ------------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q      <= ST_IDLE;
			cnt_q        <= '0;
			dirty_q      <= '0;
			rd_vld_q     <= 1'b0;
			resp_valid_q <= 1'b0;
			flag_hit_q   <= 1'b0;
			flag_miss_q  <= 1'b0;
			flag_wb_q    <= 1'b0;
		end else begin
			rd_vld_q     <= (state_q == ST_WB_READ);
			resp_valid_q <= (state_q == ST_RESPOND);
			flag_hit_q   <= 1'b0;
			flag_miss_q  <= 1'b0;
			flag_wb_q    <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (core_req_valid_i) begin // lookup on the live request
						flag_hit_q  <= cam_hit_i;
						flag_miss_q <= !cam_hit_i;
						state_q     <= cam_hit_i ? ST_RESPOND : ST_VICTIM;
					end
				end
				ST_VICTIM: begin
					cnt_q <= '0;
					if (dirty_q[plru_victim_i]) begin // dirty implies valid
						flag_wb_q <= 1'b1;
						state_q   <= ST_WB_READ;
					end else begin
						state_q <= ST_FILL_REQ;
					end
				end
				ST_WB_READ: begin
					if (last_word) begin
						cnt_q   <= '0;
						state_q <= ST_WB_SEND;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				ST_WB_SEND: begin
					if (cnt_q[BLOCK_W]) begin // command plus four words done
						cnt_q   <= '0;
						state_q <= ST_FILL_REQ;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				ST_FILL_REQ: state_q <= ST_FILL;
				ST_FILL: begin
					if (fill_pop_o) begin
						if (last_word) begin
							cnt_q           <= '0;
							dirty_q[line_q] <= 1'b0; // set again below on stores
							state_q         <= ST_RESPOND;
						end else begin
							cnt_q <= cnt_q + 1'b1;
						end
					end
				end
				ST_RESPOND: begin
					if (is_store)
						dirty_q[line_q] <= 1'b1;
					state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// request payload
	always_ff @(posedge clock_i) begin
		if (state_q == ST_IDLE && core_req_valid_i) begin
			req_q  <= core_req_i;
			hit_q  <= cam_hit_i;
			line_q <= cam_line_i;
		end
		if (state_q == ST_VICTIM)
			line_q <= plru_victim_i;
	end

	// ------------------------------------------------------------------------
	// datapath control
	// ------------------------------------------------------------------------
	assign cam_tag_o     = (state_q == ST_IDLE) ? core_req_i.addr[ADDR_W-1:BLOCK_W] : req_tag;
	assign cam_wr_o      = fill_pop_o && last_word; // tag valid after fourth word
	assign cam_wr_line_o = line_q;

	// word select from counter, except the final merge or read
	assign dmem_addr_o  = {line_q, (state_q == ST_RESPOND) ? req_word : cnt_q[BLOCK_W-1:0]};
	assign dmem_we_o    = fill_pop_o || (state_q == ST_RESPOND && is_store);
	assign dmem_wdata_o = (state_q == ST_FILL) ? fill_data_i : req_q.wdata;

	assign plru_touch_o = (state_q == ST_RESPOND);
	assign plru_line_o  = line_q;

	assign wb_push_o  = rd_vld_q;  // registered read data lands one cycle late
	assign wb_data_o  = dmem_rdata_i;
	assign wb_pop_o   = (state_q == ST_WB_SEND) && (|cnt_q);
	assign fill_pop_o = (state_q == ST_FILL) && !fill_empty_i;

	always_comb begin
		mem_cmd_valid_o = (state_q == ST_WB_SEND && cnt_q == '0) || (state_q == ST_FILL_REQ);
		mem_cmd_o.op    = (state_q == ST_WB_SEND) ? MEM_WR : MEM_RD;
		mem_cmd_o.block = (state_q == ST_WB_SEND) ? cam_rd_tag_i : req_tag;
	end

	always_comb begin
		core_resp_valid_o = resp_valid_q;
		core_resp_o.rdata = is_store ? req_q.wdata : dmem_rdata_i;
		core_resp_o.hit   = hit_q;
	end

	assign flag_hit_o       = flag_hit_q;
	assign flag_miss_o      = flag_miss_q;
	assign flag_writeback_o = flag_wb_q;

endmodule

// ==== source/word_fifo.sv ====
module word_fifo (
	input  logic                         clock_i,
	input  logic                         resetn_i,
	input  logic                         push_i,
	input  logic [cache_pkg::WORD_W-1:0] data_i,
	input  logic                         pop_i,
	output logic [cache_pkg::WORD_W-1:0] data_o,
	output logic                         empty_o
);
	import cache_pkg::*;

	// one block deep
	logic [WORD_W-1:0]  mem_q [BLOCK_WORDS];
	logic [BLOCK_W-1:0] wr_ptr_q;
	logic [BLOCK_W-1:0] rd_ptr_q;
	logic [BLOCK_W:0]   count_q;
	logic               do_push;
	logic               do_pop;

	assign empty_o = (count_q == '0);
	assign do_pop  = pop_i && !empty_o;
	assign do_push = push_i && !count_q[BLOCK_W]; // top bit set means full
	assign data_o  = mem_q[rd_ptr_q];             // head

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1; // wraps with the pointer width
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (do_push)
			mem_q[wr_ptr_q] <= data_i;
	end

endmodule

// ==== source/plru_tree.sv ====
module plru_tree (
	input  logic                         clock_i,
	input  logic                         resetn_i,
	input  logic                         touch_i,
	input  logic [cache_pkg::LINE_W-1:0] line_i,
	output logic [cache_pkg::LINE_W-1:0] victim_o
);
	import cache_pkg::*;

	// heap order, node 1 is the root and node n has children 2n and 2n+1
	logic [LINES-1:1] bits_q;
	logic [LINES-1:1] bits_d;

	// point every node on the path away from the touched line
	always_comb begin
		int node;
		bits_d = bits_q;
		node   = 1;
		if (touch_i) begin
			for (int lvl = 0; lvl < LINE_W; lvl++) begin
				bits_d[node] = ~line_i[LINE_W-1-lvl];
				node         = 2*node + int'(line_i[LINE_W-1-lvl]);
			end
		end
	end

	// walk from the root, 0 goes left
	always_comb begin
		int node;
		node = 1;
		for (int lvl = 0; lvl < LINE_W; lvl++)
			node = 2*node + int'(bits_q[node]);
		victim_o = LINE_W'(node - LINES); // leaf index back to line
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			bits_q <= '0;
		else
			bits_q <= bits_d;
	end

endmodule

// ==== source/cache_data_mem.sv ====
module cache_data_mem (
	input  logic                                           clock_i,
	input  logic [cache_pkg::LINE_W+cache_pkg::BLOCK_W-1:0] addr_i, // {line, word}
	input  logic                                           we_i,
	input  logic [cache_pkg::WORD_W-1:0]                   wdata_i,
	output logic [cache_pkg::WORD_W-1:0]                   rdata_o
);
	import cache_pkg::*;

	logic [WORD_W-1:0] mem_q [LINES*BLOCK_WORDS];

	// read returns the old word on a same-address write
	always_ff @(posedge clock_i) begin
		if (we_i)
			mem_q[addr_i] <= wdata_i;
		rdata_o <= mem_q[addr_i];
	end

endmodule

// ==== source/tag_cam.sv ====
module tag_cam (
	input  logic                         clock_i,
	input  logic                         resetn_i,
	input  logic [cache_pkg::TAG_W-1:0]  tag_i,
	output logic                         hit_o,
	output logic [cache_pkg::LINE_W-1:0] line_o,
	input  logic                         wr_i,
	input  logic [cache_pkg::LINE_W-1:0] wr_line_i,
	input  logic [cache_pkg::LINE_W-1:0] rd_line_i,
	output logic [cache_pkg::TAG_W-1:0]  rd_tag_o
);
	import cache_pkg::*;

	logic [TAG_W-1:0] tags_q [LINES];
	logic [LINES-1:0] valid_q;

	// parallel compare over all valid entries
	always_comb begin
		hit_o  = 1'b0;
		line_o = '0;
		for (int i = 0; i < LINES; i++) begin
			if (valid_q[i] && tags_q[i] == tag_i) begin // tags are unique
				hit_o  = 1'b1;
				line_o = LINE_W'(i);
			end
		end
	end

	// stored tag for building the writeback address
	assign rd_tag_o = tags_q[rd_line_i];

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			valid_q <= '0;
		else if (wr_i)
			valid_q[wr_line_i] <= 1'b1;
	end

	always_ff @(posedge clock_i) begin
		if (wr_i)
			tags_q[wr_line_i] <= tag_i;
	end

endmodule

// ==== source/cache_pkg.sv ====
package cache_pkg;

	// ------------------------------------------------------------------------
	// cache geometry
	// ------------------------------------------------------------------------
	localparam int WORD_W      = 32;
	localparam int ADDR_W      = 16;              // word address
	localparam int BLOCK_W     = 2;
	localparam int BLOCK_WORDS = 1 << BLOCK_W;    // words per block
	localparam int LINE_W      = 2;
	localparam int LINES       = 1 << LINE_W;
	localparam int TAG_W       = ADDR_W - BLOCK_W; // tag is the block address

	// memory operation, shared by core and memory side
	typedef enum logic {
		MEM_RD = 1'b0,
		MEM_WR = 1'b1
	} mem_op_e;

	typedef struct packed {
		mem_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;  // ignored on loads
	} core_req_t;

	typedef struct packed {
		logic [WORD_W-1:0] rdata;  // store data echoed back on stores
		logic              hit;
	} core_resp_t;

	typedef struct packed {
		mem_op_e          op;
		logic [TAG_W-1:0] block;   // block address, word bits dropped
	} mem_cmd_t;

	// controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_VICTIM,
		ST_WB_READ,
		ST_WB_SEND,
		ST_FILL_REQ,
		ST_FILL,
		ST_RESPOND
	} ctrl_state_e;

endpackage
